//--- hdl/led_panel_config.svh
`ifndef LED_PANEL_CONFIG_SVH
`define LED_PANEL_CONFIG_SVH

// panel geometry
`define LANE_COUNT      3
`define WORD_BITS       48
`define WORDS_PER_LANE  4
`define COLUMN_COUNT    8

// timing, in clk cycles per strobe and in strobes
`define CLK_DIV         2
`define BLANK_CYCLES    8
`define CONF_LAT_LEN    3

// lod_mode 01, gain 100, gclk_edge 0, pre_chg 1, full brightness
`define CONF_WORD       48'h63FF_FFFF_C000

`endif

//--- hdl/led_word_pkg.sv
`default_nettype none

`include "led_panel_config.svh"

package led_word_pkg;

    // grayscale word, red channel shifted out first
    typedef struct packed {
        logic [15:0] red;
        logic [15:0] green;
        logic [15:0] blue;
    } gs_word_t;

    // driver function control word
    typedef struct packed {
        logic [1:0]  lod_mode;
        logic [2:0]  gain;
        logic        gclk_edge;
        logic        pre_chg;
        logic [26:0] color_bright;
        logic [13:0] reserved;
    } conf_word_t;

    typedef union packed {
        gs_word_t   gs;
        conf_word_t conf;
    } drv_word_u;

    // one word per lane, lane 0 in the low bits
    typedef drv_word_u [`LANE_COUNT-1:0] lane_words_t;

endpackage

`default_nettype wire

//--- hdl/led_ctrl_pkg.sv
`default_nettype none

package led_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SHIFT,
        LATCH,
        BLANK,
        NEXT_COL
    } ctrl_state_e;

    // what the pending latch will commit in the drivers
    typedef enum logic {
        LAT_GS,
        LAT_CONF
    } latch_kind_e;

endpackage

`default_nettype wire

//--- hdl/drv_shift_if.sv
`default_nettype none

`include "led_panel_config.svh"

interface drv_shift_if
    import led_word_pkg::*;
();

    lane_words_t             words;
    logic                    load;
    logic                    shift;
    // current top bit of every lane
    logic [`LANE_COUNT-1:0]  msb;

    modport ctrl (
        output words,
        output load,
        output shift,
        input  msb
    );

    modport ser (
        input  words,
        input  load,
        input  shift,
        output msb
    );

endinterface

`default_nettype wire

//--- hdl/clock_enable.sv
`default_nettype none

`include "led_panel_config.svh"

module clock_enable (
    input  logic clk,
    input  logic nrst,
    output logic clk_en
);

    localparam int CNT_W = ($clog2(`CLK_DIV) > 0) ? $clog2(`CLK_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;

    // one strobe per wrap of the divider
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            div_cnt <= '0;
            clk_en  <= 1'b0;
        end else if (div_cnt == CNT_W'(`CLK_DIV - 1)) begin
            div_cnt <= '0;
            clk_en  <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            clk_en  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/framebuffer_emulator.sv
`default_nettype none

`include "led_panel_config.svh"

module framebuffer_emulator
    import led_word_pkg::*;
(
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                fb_req,
    input  logic [$clog2(`COLUMN_COUNT)-1:0]    column,
    input  logic [$clog2(`WORDS_PER_LANE)-1:0]  word_index,
    input  logic                                next_pattern,
    input  logic                                column_start,
    output lane_words_t                         fb_words
);

    logic pattern_inv;
    logic inv_now;

    // test pattern channel, tagged with where it belongs
    function automatic logic [15:0] chan_value(
        input logic       inv,
        input logic [2:0] col,
        input logic [1:0] wi,
        input logic [1:0] lane,
        input logic [1:0] ch
    );
        logic [15:0] value;
        value = {inv, col, wi, lane, ch, 6'b0};
        return inv ? ~value : value;
    endfunction

    // pattern choice held for the whole column
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pattern_inv <= 1'b0;
        end else if (column_start) begin
            pattern_inv <= next_pattern;
        end
    end

    // first request of a column already sees the new choice
    assign inv_now = column_start ? next_pattern : pattern_inv;

    always_ff @(posedge clk) begin
        if (fb_req) begin
            for (int l = 0; l < `LANE_COUNT; l++) begin
                fb_words[l].gs.red   <= chan_value(inv_now, column, word_index, 2'(l), 2'd0);
                fb_words[l].gs.green <= chan_value(inv_now, column, word_index, 2'(l), 2'd1);
                fb_words[l].gs.blue  <= chan_value(inv_now, column, word_index, 2'(l), 2'd2);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/shift_serializer.sv
`default_nettype none

`include "led_panel_config.svh"

module shift_serializer (
    input  logic                    clk,
    input  logic                    nrst,
    drv_shift_if.ser                shift_bus,
    output logic [`LANE_COUNT-1:0]  sin
);

    logic [`WORD_BITS-1:0] lane_q [`LANE_COUNT];

    // per-lane shift registers, MSB leaves first
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int l = 0; l < `LANE_COUNT; l++) begin
                lane_q[l] <= '0;
            end
        end else if (shift_bus.load) begin
            for (int l = 0; l < `LANE_COUNT; l++) begin
                lane_q[l] <= shift_bus.words[l];
            end
        end else if (shift_bus.shift) begin
            for (int l = 0; l < `LANE_COUNT; l++) begin
                lane_q[l] <= {lane_q[l][`WORD_BITS-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        for (int l = 0; l < `LANE_COUNT; l++) begin
            shift_bus.msb[l] = lane_q[l][`WORD_BITS-1];
        end
    end

    // one cycle behind the register, settles while sclk is low
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sin <= '0;
        end else begin
            sin <= shift_bus.msb;
        end
    end

endmodule

`default_nettype wire

//--- hdl/driver_controller.sv
`default_nettype none

`include "led_panel_config.svh"

module driver_controller
    import led_word_pkg::*, led_ctrl_pkg::*;
(
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                clk_en,
    input  logic                                cfg_start,
    drv_shift_if.ctrl                           shift_bus,
    input  lane_words_t                         fb_words,
    output logic                                fb_req,
    output logic [$clog2(`COLUMN_COUNT)-1:0]    column,
    output logic [$clog2(`WORDS_PER_LANE)-1:0]  word_index,
    output logic                                column_start,
    output logic                                sclk,
    output logic                                lat,
    output logic                                gclk,
    output logic                                column_ready,
    output logic                                driver_ready
);

    localparam int COL_W  = $clog2(`COLUMN_COUNT);
    localparam int WI_W   = $clog2(`WORDS_PER_LANE);
    localparam int BIT_W  = $clog2(`WORD_BITS + 1);
    localparam int STRB_W = $clog2(`BLANK_CYCLES + `CONF_LAT_LEN);

    ctrl_state_e       state;
    latch_kind_e       kind;
    logic              load_step;
    logic              cfg_pending;
    logic              gclk_phase;
    logic [BIT_W-1:0]  bit_cnt;
    logic [STRB_W-1:0] strb_cnt;
    logic [STRB_W-1:0] lat_last;
    lane_words_t       conf_words;

    // same configuration word into every lane
    always_comb begin
        for (int l = 0; l < `LANE_COUNT; l++) begin
            conf_words[l].conf = conf_word_t'(`CONF_WORD);
        end
    end

    assign shift_bus.words = (kind == LAT_CONF) ? conf_words : fb_words;
    assign shift_bus.load  = (state == LOAD) && load_step;
    // no shift after the last bit, the next load replaces the word
    assign shift_bus.shift = (state == SHIFT) && clk_en && sclk &&
                             (bit_cnt != BIT_W'(`WORD_BITS));

    assign fb_req       = (state == LOAD) && !load_step && (kind == LAT_GS);
    assign column_start = fb_req && (word_index == '0);
    assign column_ready = (state == NEXT_COL);
    assign lat_last     = (kind == LAT_CONF) ? STRB_W'(`CONF_LAT_LEN - 1) : '0;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state        <= IDLE;
            kind         <= LAT_GS;
            load_step    <= 1'b0;
            cfg_pending  <= 1'b0;
            gclk_phase   <= 1'b0;
            bit_cnt      <= '0;
            strb_cnt     <= '0;
            word_index   <= '0;
            column       <= '0;
            sclk         <= 1'b0;
            lat          <= 1'b0;
            gclk         <= 1'b0;
            driver_ready <= 1'b0;
        end else begin
            // gclk runs at a quarter of the strobe rate, parked in blanking
            if (clk_en) begin
                gclk_phase <= ~gclk_phase;
                if (gclk_phase && state != BLANK && state != NEXT_COL) begin
                    gclk <= ~gclk;
                end
            end
            case (state)
                IDLE: begin
                    if (clk_en) begin
                        driver_ready <= 1'b0;
                        word_index   <= '0;
                        bit_cnt      <= '0;
                        load_step    <= 1'b0;
                        state        <= LOAD;
                        if (cfg_pending) begin
                            kind        <= LAT_CONF;
                            cfg_pending <= 1'b0;
                        end else begin
                            kind <= LAT_GS;
                        end
                    end
                end
                // request, then load, at clk rate
                LOAD: begin
                    if (!load_step) begin
                        load_step <= 1'b1;
                    end else begin
                        load_step <= 1'b0;
                        state     <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (clk_en && !sclk) begin
                        sclk    <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (clk_en) begin
                        sclk <= 1'b0;
                        if (bit_cnt == BIT_W'(`WORD_BITS)) begin
                            bit_cnt <= '0;
                            if (kind == LAT_CONF ||
                                word_index == WI_W'(`WORDS_PER_LANE - 1)) begin
                                state <= LATCH;
                            end else begin
                                word_index <= word_index + 1'b1;
                                state      <= LOAD;
                            end
                        end
                    end
                end
                // lat rises one strobe after the last sclk fall
                LATCH: begin
                    if (clk_en && !lat) begin
                        lat      <= 1'b1;
                        strb_cnt <= '0;
                    end else if (clk_en && strb_cnt == lat_last) begin
                        lat      <= 1'b0;
                        strb_cnt <= '0;
                        if (kind == LAT_CONF) begin
                            state <= IDLE;
                        end else begin
                            gclk  <= 1'b0;
                            state <= BLANK;
                        end
                    end else if (clk_en) begin
                        strb_cnt <= strb_cnt + 1'b1;
                    end
                end
                BLANK: begin
                    if (clk_en && strb_cnt == STRB_W'(`BLANK_CYCLES - 1)) begin
                        strb_cnt <= '0;
                        state    <= NEXT_COL;
                    end else if (clk_en) begin
                        strb_cnt <= strb_cnt + 1'b1;
                    end
                end
                NEXT_COL: begin
                    state        <= IDLE;
                    column       <= (column == COL_W'(`COLUMN_COUNT - 1)) ? '0 : column + 1'b1;
                    // frame done once the last column is out
                    driver_ready <= (column == COL_W'(`COLUMN_COUNT - 1));
                end
                default: state <= IDLE;
            endcase
            if (cfg_start) begin
                cfg_pending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/column_mux.sv
`default_nettype none

`include "led_panel_config.svh"

module column_mux (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      column_ready,
    output logic [`COLUMN_COUNT-1:0]  mux_out
);

    // one-hot select, column 0 after reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mux_out <= `COLUMN_COUNT'(1);
        end else if (column_ready) begin
            mux_out <= {mux_out[`COLUMN_COUNT-2:0], mux_out[`COLUMN_COUNT-1]};
        end
    end

endmodule

`default_nettype wire

//--- hdl/led_panel_top.sv
`default_nettype none

`include "led_panel_config.svh"

module led_panel_top
    import led_word_pkg::*;
(
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      cfg_start,
    input  logic                      next_pattern,
    output logic [`LANE_COUNT-1:0]    sin,
    output logic                      sclk,
    output logic                      lat,
    output logic                      gclk,
    output logic [`COLUMN_COUNT-1:0]  mux_out,
    output logic                      driver_ready
);

    logic                                clk_en;
    logic                                fb_req;
    logic                                column_start;
    logic                                column_ready;
    logic [$clog2(`COLUMN_COUNT)-1:0]    column;
    logic [$clog2(`WORDS_PER_LANE)-1:0]  word_index;
    lane_words_t                         fb_words;

    drv_shift_if shift_bus ();

    // strobe for all panel timing
    clock_enable main_clock_enable (
        .clk    (clk),
        .nrst   (nrst),
        .clk_en (clk_en)
    );

    framebuffer_emulator main_fb_emulator (
        .clk          (clk),
        .nrst         (nrst),
        .fb_req       (fb_req),
        .column       (column),
        .word_index   (word_index),
        .next_pattern (next_pattern),
        .column_start (column_start),
        .fb_words     (fb_words)
    );

    driver_controller main_driver_controller (
        .clk          (clk),
        .nrst         (nrst),
        .clk_en       (clk_en),
        .cfg_start    (cfg_start),
        .shift_bus    (shift_bus.ctrl),
        .fb_words     (fb_words),
        .fb_req       (fb_req),
        .column       (column),
        .word_index   (word_index),
        .column_start (column_start),
        .sclk         (sclk),
        .lat          (lat),
        .gclk         (gclk),
        .column_ready (column_ready),
        .driver_ready (driver_ready)
    );

    shift_serializer main_serializer (
        .clk       (clk),
        .nrst      (nrst),
        .shift_bus (shift_bus.ser),
        .sin       (sin)
    );

    column_mux main_column_mux (
        .clk          (clk),
        .nrst         (nrst),
        .column_ready (column_ready),
        .mux_out      (mux_out)
    );

endmodule

`default_nettype wire

//--- bench/led_panel_assert.sv
`default_nettype none

`include "led_panel_config.svh"

module led_panel_assert (
    input logic                      clk,
    input logic                      nrst,
    input logic                      sclk,
    input logic                      lat,
    input logic [`LANE_COUNT-1:0]    sin,
    input logic [`COLUMN_COUNT-1:0]  mux_out
);

    // assertion failures so far
    int fail_count = 0;

    // data lines only move while the drivers are not sampling
    sin_moves_with_sclk_low: assert property (
        @(posedge clk) disable iff (!nrst) !$stable(sin) |-> !sclk
    ) else begin
        $error("sin changed while sclk was high");
        fail_count++;
    end

    sclk_quiet_during_lat: assert property (
        @(posedge clk) disable iff (!nrst) lat |-> $stable(sclk)
    ) else begin
        $error("sclk toggled while lat was high");
        fail_count++;
    end

    lat_rises_with_sclk_low: assert property (
        @(posedge clk) disable iff (!nrst) $rose(lat) |-> !sclk
    ) else begin
        $error("lat rose while sclk was high");
        fail_count++;
    end

    // exactly one column driven at any time
    mux_out_one_hot: assert property (
        @(posedge clk) disable iff (!nrst) $onehot(mux_out)
    ) else begin
        $error("mux_out is not one-hot");
        fail_count++;
    end

endmodule

bind led_panel_top led_panel_assert panel_assert_i (
    .clk     (clk),
    .nrst    (nrst),
    .sclk    (sclk),
    .lat     (lat),
    .sin     (sin),
    .mux_out (mux_out)
);

`default_nettype wire

//--- bench/led_panel_tb.sv
`default_nettype none

`include "led_panel_config.svh"

module led_panel_tb;

    localparam int STREAM_BITS   = `WORD_BITS * `WORDS_PER_LANE;
    localparam int GS_COLUMNS    = 12;
    localparam int CONF_WRITES   = 2;
    localparam int COLUMN_CYCLES = `WORDS_PER_LANE * (2 * `WORD_BITS + 4) * `CLK_DIV +
                                   (`CONF_LAT_LEN + `BLANK_CYCLES + 6) * `CLK_DIV;
    localparam int CYCLE_LIMIT   = (GS_COLUMNS + CONF_WRITES) * COLUMN_CYCLES + 1000;

    logic                     clk;
    logic                     nrst;
    logic                     cfg_start;
    logic                     next_pattern;
    logic [`LANE_COUNT-1:0]   sin;
    logic                     sclk;
    logic                     lat;
    logic                     gclk;
    logic [`COLUMN_COUNT-1:0] mux_out;
    logic                     driver_ready;

    int error_count   = 0;
    int check_count   = 0;
    int cycle_count   = 0;
    int gs_latches    = 0;
    int conf_requests = 0;
    int conf_latches  = 0;
    int advances      = 0;
    int rise_count    = 0;
    int lat_cycles    = 0;
    int gclk_toggles  = 0;

    logic                     blanking   = 1'b0;
    logic                     conf_latch = 1'b0;
    logic                     prev_nrst  = 1'b0;
    logic                     prev_sclk  = 1'b0;
    logic                     prev_lat   = 1'b0;
    logic                     prev_gclk  = 1'b0;
    logic [`COLUMN_COUNT-1:0] prev_mux   = '0;
    logic [STREAM_BITS-1:0]   stream [`LANE_COUNT];
    logic [31:0]              rand_state;

    led_panel_top dut_i (
        .clk          (clk),
        .nrst         (nrst),
        .cfg_start    (cfg_start),
        .next_pattern (next_pattern),
        .sin          (sin),
        .sclk         (sclk),
        .lat          (lat),
        .gclk         (gclk),
        .mux_out      (mux_out),
        .driver_ready (driver_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected grayscale word from column, word, lane and inversion
    function automatic logic [47:0] pattern_word(input int col, input int word,
                                                 input int lane, input logic inv);
        logic [47:0] value;
        logic [15:0] chan;
        value = '0;
        for (int ch = 0; ch < 3; ch++) begin
            chan = {inv, 3'(col), 2'(word), 2'(lane), 2'(ch), 6'd0};
            if (inv) begin
                chan = ~chan;
            end
            value[47 - 16 * ch -: 16] = chan;
        end
        return value;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (expected == actual) else begin
            error_count++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("at t=%0t %s", $time, what);
        end
    endtask

    task automatic check_reset_values();
        check_equal("sclk", 64'(1'b0), 64'(sclk));
        check_equal("lat", 64'(1'b0), 64'(lat));
        check_equal("gclk", 64'(1'b0), 64'(gclk));
        check_equal("sin", 64'(0), 64'(sin));
        check_equal("driver_ready", 64'(1'b0), 64'(driver_ready));
        check_equal("mux_out", 64'(1), 64'(mux_out));
    endtask

    // words shifted since the last latch, compared when lat rises
    task automatic check_latch();
        int col;
        conf_latch = (conf_requests > conf_latches);
        check_true("gclk did not toggle before the latch", gclk_toggles > 0);
        gclk_toggles = 0;
        if (conf_latch) begin
            check_equal("sclk rises", 64'(`WORD_BITS), 64'(rise_count));
            for (int l = 0; l < `LANE_COUNT; l++) begin
                check_equal($sformatf("sin[%0d] conf word", l), 64'(`CONF_WORD),
                            64'(stream[l][`WORD_BITS-1:0]));
            end
        end else begin
            col = gs_latches % `COLUMN_COUNT;
            check_equal("sclk rises", 64'(STREAM_BITS), 64'(rise_count));
            check_equal("mux_out", 64'(1) << col, 64'(mux_out));
            for (int l = 0; l < `LANE_COUNT; l++) begin
                for (int w = 0; w < `WORDS_PER_LANE; w++) begin
                    check_equal($sformatf("sin[%0d] word %0d", l, w),
                                64'(pattern_word(col, w, l, next_pattern)),
                                64'(stream[l][STREAM_BITS-1-`WORD_BITS*w -: `WORD_BITS]));
                end
            end
        end
        rise_count = 0;
        lat_cycles = 0;
    endtask

    task automatic finish_latch();
        if (conf_latch) begin
            check_equal("lat cycles", 64'(`CONF_LAT_LEN * `CLK_DIV), 64'(lat_cycles));
            conf_latches++;
        end else begin
            check_equal("lat cycles", 64'(`CLK_DIV), 64'(lat_cycles));
            gs_latches++;
            blanking = 1'b1;
        end
    endtask

    task automatic check_column_step();
        advances++;
        check_equal("mux_out", 64'(1) << (advances % `COLUMN_COUNT), 64'(mux_out));
        check_true("column advanced without a blanking gap", blanking);
        blanking = 1'b0;
    endtask

    // outputs sampled on the falling edge, away from every update
    always @(negedge clk) begin
        if (!nrst || !prev_nrst) begin
            check_reset_values();
            for (int l = 0; l < `LANE_COUNT; l++) begin
                stream[l] = '0;
            end
        end else begin
            if (sclk && !prev_sclk) begin
                rise_count++;
                for (int l = 0; l < `LANE_COUNT; l++) begin
                    stream[l] = {stream[l][STREAM_BITS-2:0], sin[l]};
                end
            end
            if (gclk != prev_gclk && !blanking) begin
                gclk_toggles++;
            end
            if (lat && !prev_lat) begin
                check_latch();
            end
            if (lat) begin
                lat_cycles++;
            end
            if (!lat && prev_lat) begin
                finish_latch();
            end
            if (blanking) begin
                check_equal("gclk", 64'(1'b0), 64'(gclk));
            end
            if (mux_out != prev_mux) begin
                check_column_step();
            end
        end
        prev_nrst = nrst;
        prev_sclk = sclk;
        prev_lat  = lat;
        prev_gclk = gclk;
        prev_mux  = mux_out;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timed out after %0d cycles before all columns were shown", cycle_count);
            $display("checks %0d, errors %0d, assertion failures %0d, columns %0d",
                     check_count, error_count, dut_i.panel_assert_i.fail_count, advances);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        nrst         = 1'b0;
        cfg_start    = 1'b0;
        rand_state   = next_random(32'haf925272);
        next_pattern = rand_state[31];
        repeat (4) @(posedge clk);
        #1 nrst = 1'b1;
        for (int step = 0; step < GS_COLUMNS; step++) begin
            while (gs_latches <= step) begin
                @(posedge clk);
            end
            // new pattern choice during blanking, ahead of the next column
            #1;
            rand_state   = next_random(rand_state);
            next_pattern = rand_state[31];
            if (step == 2 || step == 7) begin
                cfg_start = 1'b1;
                conf_requests++;
                @(posedge clk);
                #1 cfg_start = 1'b0;
            end
        end
        while (advances < GS_COLUMNS) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d, columns %0d",
                 check_count, error_count, dut_i.panel_assert_i.fail_count, advances);
        if (error_count == 0 && dut_i.panel_assert_i.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/led_word_pkg.sv
hdl/led_ctrl_pkg.sv
hdl/drv_shift_if.sv
hdl/clock_enable.sv
hdl/framebuffer_emulator.sv
hdl/shift_serializer.sv
hdl/driver_controller.sv
hdl/column_mux.sv
hdl/led_panel_top.sv
bench/led_panel_assert.sv
bench/led_panel_tb.sv

//--- run.sh
#!/bin/sh
# builds the LED panel testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f sources.f --top-module led_panel_tb -o led_panel_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/led_panel_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
